//--- logic/cart_pkg.sv
////////////////////////////////////////////////////////////
// Memory side types for the cartridge mapper
// CPU addresses are word addresses and bit 0 is never carried
// SDRAM addresses are word addresses into a 16M word space
////////////////////////////////////////////////////////////
`default_nettype none

package cart_pkg;

	// CPU word address, byte address bits 23 to 1
	typedef logic [23:1] cpu_addr_t;

	// SDRAM word address
	typedef logic [23:0] mem_addr_t;

	typedef logic [15:0] data_t; // Bus data word

	// One mapper bank, selects a 512 KB window
	typedef logic [4:0] bank_t;

	localparam int BANK_COUNT = 8;

	// All banks packed, bank n at bits 5n+4 to 5n
	typedef logic [BANK_COUNT*$bits(bank_t)-1:0] bank_table_t;

	// ROM size mask over byte address bits 23 to 13
	typedef logic [23:13] rom_mask_t;

endpackage

`default_nettype wire

//--- logic/loader_pkg.sv
////////////////////////////////////////////////////////////
// Download stream and cartridge header definitions
// Every ROM index is taken as a cartridge image
////////////////////////////////////////////////////////////
`default_nettype none

package loader_pkg;

	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t; // Byte address of the download

	localparam logic [5:0] IDX_ROM_LAST = 6'd1; // Highest ROM index, low six bits
	localparam dl_index_t  IDX_CHEAT    = 8'hFF;

	localparam dl_addr_t HDR_REGION_ADDR = 25'h1F0; // Region letter in the header

	typedef logic [1:0] region_t;
	localparam region_t REGION_JAPAN  = 2'd0;
	localparam region_t REGION_USA    = 2'd1;
	localparam region_t REGION_EUROPE = 2'd2;

	// Cheat code, words arrive big endian from the host
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	function automatic logic is_rom_index(input dl_index_t index);
		return index[5:0] <= IDX_ROM_LAST;
	endfunction

endpackage

`default_nettype wire

//--- logic/download_if.sv
////////////////////////////////////////////////////////////
// Download stream from the host, one word per wr strobe
// No back-pressure, a strobe may come on every cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface download_if
	import cart_pkg::*, loader_pkg::*;
();

	logic      active; // Download in progress
	dl_index_t index;
	logic      wr;     // One cycle write strobe
	dl_addr_t  addr;
	data_t     data;

	modport source (output active, index, wr, addr, data);

	// Each sink decodes ROM or cheat writes on its own
	modport sink (input active, index, wr, addr, data);

endinterface

`default_nettype wire

//--- logic/cart_header_sniffer.sv
////////////////////////////////////////////////////////////
// Picks the region letter out of the ROM header and
// builds the ROM size mask while the image streams in.
// The mask is only valid once the whole image is loaded
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cart_header_sniffer
	import cart_pkg::*, loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	download_if.sink    dl,

	output region_t     region_detect,
	output rom_mask_t   rom_mask
);

	logic rom_wr;
	logic hdr_hit;
	logic restart;

	assign rom_wr  = dl.active & dl.wr & is_rom_index(dl.index);
	assign hdr_hit = rom_wr && (dl.addr == HDR_REGION_ADDR);
	assign restart = (dl.addr == '0); // First word of a new image

	////////////////////////////////////////////////////////////
	// Region letter

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_detect <= REGION_JAPAN;
		end else if (hdr_hit) begin
			// Only the first letter of the region field is looked at
			if (dl.data[7:0] == "J") begin
				region_detect <= REGION_JAPAN;
			end else if (dl.data[7:0] == "U") begin
				region_detect <= REGION_USA;
			end else begin
				region_detect <= REGION_EUROPE; // Any other letter
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Size mask

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask <= '0;
		end else if (rom_wr) begin
			if (restart) begin
				rom_mask <= dl.addr[23:13];
			end else begin
				rom_mask <= rom_mask | dl.addr[23:13]; // Highest address seen so far
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/region_select.sv
////////////////////////////////////////////////////////////
// Region register with manual override. region_reset holds
// the console in reset for 2^REGION_HOLD_BITS-1 cycles
// after the last change, and again after reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module region_select
	import loader_pkg::*;
#(
	parameter int REGION_HOLD_BITS = 16
) (
	input  logic       clk_sys,
	input  logic       reset,

	input  region_t    region_detect,
	input  logic [1:0] region_sel,   // 0 auto, 1 JP, 2 US, 3 EU

	output region_t    region,
	output logic       region_reset
);

	region_t                     region_next;
	logic [REGION_HOLD_BITS-1:0] settle_cnt;

	assign region_next = (region_sel != 2'd0) ? region_t'(region_sel - 2'd1)
	                                           : region_detect;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region     <= REGION_JAPAN;
			settle_cnt <= '0;
		end else begin
			region <= region_next;
			if (region != region_next) begin
				settle_cnt <= '0; // Restart settle on every change
			end else if (~&settle_cnt) begin
				settle_cnt <= settle_cnt + 1'b1;
			end
		end
	end

	assign region_reset = ~&settle_cnt; // Saturates at all ones

endmodule

`default_nettype wire

//--- logic/bank_regs.sv
////////////////////////////////////////////////////////////
// Bank registers of the large ROM mapper.
// Writes are taken only for images over 4 MB, and
// window 0 is fixed to bank 0
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bank_regs
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        dl_active,
	input  rom_mask_t   rom_mask,

	input  logic        page_wr,
	input  logic [2:0]  page_sel,
	input  bank_t       page_data,

	output bank_table_t bank_table
);

	bank_t banks [BANK_COUNT];
	logic  big_rom;
	logic  page_ok;

	assign big_rom = |rom_mask[23:22]; // Image reaches past 4 MB
	assign page_ok = page_wr && (page_sel != 3'd0) && big_rom;

	always_ff @(posedge clk_sys) begin
		if (reset | dl_active) begin
			// Identity mapping, bank n in window n
			for (int i = 0; i < BANK_COUNT; i++) begin
				banks[i] <= bank_t'(i);
			end
		end else if (page_ok) begin
			banks[page_sel] <= page_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Pack for the mapper

	always_comb begin
		for (int i = 0; i < BANK_COUNT; i++) begin
			bank_table[i*$bits(bank_t) +: $bits(bank_t)] = banks[i];
		end
	end

endmodule

`default_nettype wire

//--- logic/rom_mapper.sv
////////////////////////////////////////////////////////////
// Turns CPU reads and ROM download writes into SDRAM
// requests one cycle later. A download write wins over
// a read in the same cycle and the read is lost
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_mapper
	import cart_pkg::*, loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	download_if.sink    dl,
	input  bank_table_t bank_table,
	input  rom_mask_t   rom_mask,

	input  logic        rd_req,
	input  cpu_addr_t   rd_addr,

	output logic        mem_stb,
	output logic        mem_we,
	output mem_addr_t   mem_addr,
	output data_t       mem_wdata
);

	logic      rom_wr;
	bank_t     rd_bank;
	cpu_addr_t rom_addr;

	assign rom_wr  = dl.active & dl.wr & is_rom_index(dl.index);
	assign rd_bank = bank_table[rd_addr[21:19]*$bits(bank_t) +: $bits(bank_t)];

	// Bank replaces window bits, then wrap to the image size
	assign rom_addr = {rd_bank, rd_addr[18:1]} & {rom_mask, 12'hFFF};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_stb <= 1'b0;
			mem_we  <= 1'b0;
		end else begin
			mem_stb <= rom_wr | rd_req;
			mem_we  <= rom_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			mem_addr  <= {2'b00, dl.addr[22:1]};
			mem_wdata <= {dl.data[7:0], dl.data[15:8]}; // Host order is byte swapped
		end else if (rd_req) begin
			mem_addr  <= {2'b00, rom_addr[22:1]}; // Cart ROM in the low 8 MB
		end
	end

endmodule

`default_nettype wire

//--- logic/cheat_code_loader.sv
////////////////////////////////////////////////////////////
// Builds 128-bit cheat codes from the cheat download index.
// A code is 16 bytes and offset 14 must come last
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	download_if.sink    dl,

	output cheat_code_t cheat_code,
	output logic        cheat_stb,   // Code complete
	output logic        cheat_clear  // New cheat list starts
);

	logic cheat_wr;

	assign cheat_wr = dl.active & dl.wr & (dl.index == IDX_CHEAT);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_stb   <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_stb   <= cheat_wr && (dl.addr[3:0] == 4'd14);
			cheat_clear <= cheat_wr && (dl.addr == '0);
		end
	end

	////////////////////////////////////////////////////////////
	// Field assembly, low word first

	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (dl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dl.data;
				4'd2:  cheat_code.flags[31:16]   <= dl.data;
				4'd4:  cheat_code.address[15:0]  <= dl.data;
				4'd6:  cheat_code.address[31:16] <= dl.data;
				4'd8:  cheat_code.compare[15:0]  <= dl.data;
				4'd10: cheat_code.compare[31:16] <= dl.data;
				4'd12: cheat_code.replace[15:0]  <= dl.data;
				4'd14: cheat_code.replace[31:16] <= dl.data; // Last word
				default: ; // Odd offsets never come on a word stream
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/cart_loader_top.sv
////////////////////////////////////////////////////////////
// Cartridge loading and mapping, plain ports to the core.
// All strobes are single cycle with no back-pressure
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top
	import cart_pkg::*, loader_pkg::*;
#(
	parameter int REGION_HOLD_BITS = 16
) (
	input  logic        clk_sys,
	input  logic        reset,

	// Download stream
	input  logic        dl_active,
	input  logic        dl_wr,
	input  dl_index_t   dl_index,
	input  dl_addr_t    dl_addr,
	input  data_t       dl_data,

	input  logic [1:0]  region_sel,

	// Mapper page writes from the CPU
	input  logic        page_wr,
	input  logic [2:0]  page_sel,
	input  bank_t       page_data,

	input  logic        rd_req,
	input  cpu_addr_t   rd_addr,

	// SDRAM request
	output logic        mem_stb,
	output logic        mem_we,
	output mem_addr_t   mem_addr,
	output data_t       mem_wdata,

	output region_t     region,
	output logic        region_reset,

	output cheat_code_t cheat_code,
	output logic        cheat_stb,
	output logic        cheat_clear
);

	region_t     region_detect;
	rom_mask_t   rom_mask;
	bank_table_t bank_table;

	download_if dl_bus ();

	// Source side of the stream
	assign dl_bus.active = dl_active;
	assign dl_bus.index  = dl_index;
	assign dl_bus.wr     = dl_wr;
	assign dl_bus.addr   = dl_addr;
	assign dl_bus.data   = dl_data;

	cart_header_sniffer u_sniffer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl_bus.sink),
		.region_detect (region_detect),
		.rom_mask      (rom_mask)
	);

	region_select #(
		.REGION_HOLD_BITS (REGION_HOLD_BITS)
	) u_region (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.region_detect (region_detect),
		.region_sel    (region_sel),
		.region        (region),
		.region_reset  (region_reset)
	);

	bank_regs u_banks (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.rom_mask   (rom_mask),
		.page_wr    (page_wr),
		.page_sel   (page_sel),
		.page_data  (page_data),
		.bank_table (bank_table)
	);

	rom_mapper u_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl_bus.sink),
		.bank_table (bank_table),
		.rom_mask   (rom_mask),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.mem_stb    (mem_stb),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	cheat_code_loader u_cheats (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl_bus.sink),
		.cheat_code  (cheat_code),
		.cheat_stb   (cheat_stb),
		.cheat_clear (cheat_clear)
	);

endmodule

`default_nettype wire

//--- testbench/tb_cart_loader_checks.svh
////////////////////////////////////////////////////////////
// Compare tasks and expected value helpers.
// Included inside tb_cart_loader, uses its error counters
////////////////////////////////////////////////////////////
`ifndef TB_CART_LOADER_CHECKS_SVH
`define TB_CART_LOADER_CHECKS_SVH

task automatic addr_check(input string name, input mem_addr_t expected,
		input mem_addr_t actual);
	checks++;
	if (actual !== expected) begin
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

task automatic data_check(input string name, input data_t expected, input data_t actual);
	checks++;
	if (actual !== expected) begin
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

task automatic region_check(input string name, input region_t expected,
		input region_t actual);
	checks++;
	if (actual !== expected) begin
		$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		errors++;
	end
endtask

task automatic code_check(input string name, input cheat_code_t expected,
		input cheat_code_t actual);
	checks++;
	if (actual !== expected) begin
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

// Single strobe or enable levels
task automatic level_check(input string name, input logic expected, input logic actual);
	checks++;
	if (actual !== expected) begin
		$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
		errors++;
	end
endtask

// Cycle counts such as strobe latency and settle length
task automatic count_check(input string name, input int expected, input int actual);
	checks++;
	if (actual != expected) begin
		$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		errors++;
	end
endtask

////////////////////////////////////////////////////////////
// Expected values

function automatic data_t swap_bytes(input data_t d);
	return data_t'((d >> 8) | ((d & 16'h00FF) << 8));
endfunction

function automatic mem_addr_t expect_wr_addr(input dl_addr_t a);
	return mem_addr_t'((a & 25'h07FFFFF) >> 1); // Byte to word address within 8 MB
endfunction

function automatic rom_mask_t size_mask(input dl_addr_t last_addr);
	return last_addr[23:13]; // Image written from 0 up to last_addr
endfunction

function automatic mem_addr_t expect_read(input logic [23:0] byte_addr, input bank_t bank,
		input rom_mask_t mask);
	logic [23:0] a;
	a = {bank, 19'h0} | (byte_addr & 24'h07FFFF); // Bank selects a 512 KB window
	a = a & {mask, 13'h1FFF};
	return {2'b00, a[22:1]};
endfunction

// Fields from the top are flags, address, compare, replace
function automatic cheat_code_t place_cheat_word(input cheat_code_t code, input int offset,
		input data_t word);
	logic [127:0] flat;
	int           lsb;
	flat = code;
	lsb  = 96 - 32 * (offset / 4) + 16 * ((offset / 2) % 2);
	flat[lsb +: 16] = word;
	return cheat_code_t'(flat);
endfunction

`endif

//--- testbench/tb_cart_loader.sv
////////////////////////////////////////////////////////////
// Table driven testbench for the cartridge loader.
// REGION_HOLD_BITS is 4, so a region settle lasts 15 cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader
	import cart_pkg::*, loader_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int HOLD_BITS    = 4;
	localparam int HOLD_CYCLES  = 2**HOLD_BITS - 1;
	localparam int STROBE_LIMIT = 4;
	localparam int SETTLE_LIMIT = 2**HOLD_BITS + 4;
	localparam int ENTRY_CYCLES = SETTLE_LIMIT + STROBE_LIMIT + 4; // Worst case per entry

	localparam logic [1:0] OP_DL     = 2'd0; // ROM or cheat download write
	localparam logic [1:0] OP_PAGE   = 2'd1;
	localparam logic [1:0] OP_READ   = 2'd2;
	localparam logic [1:0] OP_REGION = 2'd3;

	localparam int SEL_MEM   = 0;
	localparam int SEL_CHEAT = 1;
	localparam int SEL_CLEAR = 2;

	typedef struct packed {
		logic [1:0]  op;
		dl_index_t   index;
		dl_addr_t    addr;   // Page select for page writes, CPU byte address for reads
		data_t       data;   // Page data or region_sel
		mem_addr_t   exp_addr;
		data_t       exp_data;
		region_t     exp_region;
		cheat_code_t exp_code;
	} entry_t;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active;
	logic        dl_wr;
	dl_index_t   dl_index;
	dl_addr_t    dl_addr;
	data_t       dl_data;
	logic [1:0]  region_sel;
	logic        page_wr;
	logic [2:0]  page_sel;
	bank_t       page_data;
	logic        rd_req;
	cpu_addr_t   rd_addr;
	logic        mem_stb;
	logic        mem_we;
	mem_addr_t   mem_addr;
	data_t       mem_wdata;
	region_t     region;
	logic        region_reset;
	cheat_code_t cheat_code;
	logic        cheat_stb;
	logic        cheat_clear;

	entry_t entries[$];
	string  names[$];
	bit     table_ready = 1'b0;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     failed_tests = 0;

	`include "tb_cart_loader_checks.svh"

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	cart_loader_top #(
		.REGION_HOLD_BITS (HOLD_BITS)
	) uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.region_sel   (region_sel),
		.page_wr      (page_wr),
		.page_sel     (page_sel),
		.page_data    (page_data),
		.rd_req       (rd_req),
		.rd_addr      (rd_addr),
		.mem_stb      (mem_stb),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.region       (region),
		.region_reset (region_reset),
		.cheat_code   (cheat_code),
		.cheat_stb    (cheat_stb),
		.cheat_clear  (cheat_clear)
	);

	task automatic note_failure(input string name, input string what);
		$display("ERROR in %s: %s", name, what);
		errors++;
	endtask

	function automatic logic strobe_level(input int sel);
		case (sel)
			SEL_MEM:   return mem_stb;
			SEL_CHEAT: return cheat_stb;
			default:   return cheat_clear;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Table

	task automatic add_entry(input string name, input logic [1:0] op, input dl_index_t index,
			input dl_addr_t addr, input data_t data, input mem_addr_t exp_addr,
			input data_t exp_data, input region_t exp_region, input cheat_code_t exp_code);
		entry_t e;
		e = '{op, index, addr, data, exp_addr, exp_data, exp_region, exp_code};
		entries.push_back(e);
		names.push_back(name);
	endtask

	task automatic add_rom_write(input string name, input dl_index_t index,
			input dl_addr_t addr, input data_t data);
		add_entry(name, OP_DL, index, addr, data, expect_wr_addr(addr), swap_bytes(data),
			REGION_JAPAN, '0);
	endtask

	task automatic add_read(input string name, input logic [23:0] byte_addr,
			input bank_t bank, input rom_mask_t mask);
		add_entry(name, OP_READ, 8'd0, {1'b0, byte_addr}, 16'd0,
			expect_read(byte_addr, bank, mask), '0, REGION_JAPAN, '0);
	endtask

	task automatic build_table();
		int          seed;
		data_t       word;
		cheat_code_t code;
		rom_mask_t   mask_1m;
		rom_mask_t   mask_6m;
		seed    = 53;
		code    = '0;
		mask_1m = size_mask(25'h0FFFFE);
		mask_6m = size_mask(25'h5FFFFE);
		add_rom_write("rom write index 0", 8'd0, 25'h000100, 16'h1234);
		add_rom_write("rom write index 1", 8'd1, 25'h1ABCDE, 16'hA55A);
		add_rom_write("header region U", 8'd0, HDR_REGION_ADDR, {8'h20, "U"});
		add_entry("region auto USA", OP_REGION, 8'd0, '0, 16'd0, '0, '0, REGION_USA, '0);
		add_entry("region forced EU", OP_REGION, 8'd0, '0, 16'd3, '0, '0, REGION_EUROPE, '0);
		// 1 MB image, too small for paging
		add_rom_write("1MB first word", 8'd0, 25'h000000, 16'h0001);
		add_rom_write("1MB last word", 8'd0, 25'h0FFFFE, 16'hBEEF);
		add_entry("1MB page ignored", OP_PAGE, 8'd0, 25'd6, 16'd9, '0, '0, REGION_JAPAN, '0);
		add_read("1MB read window 6", 24'h32468A, 5'd6, mask_1m);
		// 6 MB image
		add_rom_write("6MB first word", 8'd0, 25'h000000, 16'h0002);
		add_rom_write("6MB last word", 8'd0, 25'h5FFFFE, 16'hCAFE);
		add_entry("6MB page 6 bank 9", OP_PAGE, 8'd0, 25'd6, 16'd9, '0, '0, REGION_JAPAN, '0);
		add_entry("6MB page 0 ignored", OP_PAGE, 8'd0, 25'd0, 16'd3, '0, '0, REGION_JAPAN, '0);
		add_read("6MB read window 6", 24'h32468A, 5'd9, mask_6m);
		add_read("6MB read window 7", 24'h3A468A, 5'd7, mask_6m);
		add_read("6MB read window 0", 24'h02468A, 5'd0, mask_6m);
		for (int i = 0; i < 8; i++) begin
			word = data_t'($random(seed));
			code = place_cheat_word(code, 2 * i, word);
			add_entry($sformatf("cheat word %0d", i), OP_DL, IDX_CHEAT, dl_addr_t'(2 * i), word,
				'0, '0, REGION_JAPAN, code);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stepping

	task automatic expect_strobe(input string name, input int sel, input string what,
			output bit seen);
		int waited;
		waited = 1;
		@(negedge clk_sys);
		while (!strobe_level(sel) && waited <= STROBE_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		seen = strobe_level(sel);
		if (seen) begin
			count_check({name, " latency"}, 1, waited);
		end else begin
			note_failure(name, {what, " never arrived"});
		end
	endtask

	// Counts the cycles region_reset is high, starting at its rise
	task automatic measure_settle(input string name);
		int waited;
		int held;
		waited = 0;
		held   = 0;
		@(negedge clk_sys);
		while (!region_reset && waited < STROBE_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!region_reset) begin
			note_failure(name, "region_reset did not rise");
		end else begin
			while (region_reset && held < SETTLE_LIMIT) begin
				held++;
				@(negedge clk_sys);
			end
			count_check({name, " settle"}, HOLD_CYCLES, held);
		end
	endtask

	task automatic apply_entry(input entry_t e, input string name);
		bit seen;
		@(posedge clk_sys);
		case (e.op)
			OP_DL: begin
				dl_active <= 1'b1;
				dl_wr     <= 1'b1;
				dl_index  <= e.index;
				dl_addr   <= e.addr;
				dl_data   <= e.data;
			end
			OP_PAGE: begin
				page_wr   <= 1'b1;
				page_sel  <= e.addr[2:0];
				page_data <= e.data[4:0];
			end
			OP_READ: begin
				rd_req  <= 1'b1;
				rd_addr <= e.addr[23:1];
			end
			default: region_sel <= e.data[1:0];
		endcase
		if (e.op == OP_REGION) begin
			measure_settle(name);
			region_check(name, e.exp_region, region);
		end else begin
			@(posedge clk_sys);
			dl_active <= 1'b0;
			dl_wr     <= 1'b0;
			page_wr   <= 1'b0;
			rd_req    <= 1'b0;
			if (e.op == OP_PAGE) begin
				@(negedge clk_sys);
				level_check({name, " mem_stb"}, 1'b0, mem_stb);
			end else if (e.op == OP_READ || e.index != IDX_CHEAT) begin
				expect_strobe(name, SEL_MEM, "mem_stb", seen);
				if (seen) begin
					level_check({name, " mem_we"}, e.op == OP_DL, mem_we);
					addr_check(name, e.exp_addr, mem_addr);
					if (e.op == OP_DL) data_check(name, e.exp_data, mem_wdata);
				end
			end else if (e.addr == '0) begin
				expect_strobe(name, SEL_CLEAR, "cheat_clear", seen);
			end else if (e.addr[3:0] == 4'd14) begin
				expect_strobe(name, SEL_CHEAT, "cheat_stb", seen);
				if (seen) code_check(name, e.exp_code, cheat_code);
			end else begin
				@(negedge clk_sys);
				if (cheat_stb || cheat_clear || mem_stb) begin
					note_failure(name, "strobe raised by a cheat word in mid code");
				end
			end
		end
	endtask

	task automatic report_test(input string name, input int first_err);
		tests++;
		if (errors == first_err) begin
			$display("%-24s ok", name);
		end else begin
			failed_tests++;
			$display("%-24s FAILED", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin : main_seq
		int first_err;
		reset      <= 1'b1;
		dl_active  <= 1'b0;
		dl_wr      <= 1'b0;
		dl_index   <= '0;
		dl_addr    <= '0;
		dl_data    <= '0;
		region_sel <= 2'd0;
		page_wr    <= 1'b0;
		page_sel   <= '0;
		page_data  <= '0;
		rd_req     <= 1'b0;
		rd_addr    <= '0;
		build_table();
		table_ready = 1'b1;

		first_err = errors;
		@(posedge clk_sys);
		@(negedge clk_sys);
		level_check("reset mem_stb", 1'b0, mem_stb);
		level_check("reset cheat_stb", 1'b0, cheat_stb);
		level_check("reset cheat_clear", 1'b0, cheat_clear);
		@(posedge clk_sys);
		reset <= 1'b0;
		measure_settle("reset");
		report_test("reset", first_err);

		for (int n = 0; n < entries.size(); n++) begin
			first_err = errors;
			apply_entry(entries[n], names[n]);
			report_test(names[n], first_err);
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (table_ready);
		#((entries.size() + 2) * ENTRY_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the table was finished");
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+testbench
logic/cart_pkg.sv
logic/loader_pkg.sv
logic/download_if.sv
logic/cart_header_sniffer.sv
logic/region_select.sv
logic/bank_regs.sv
logic/rom_mapper.sv
logic/cheat_code_loader.sv
logic/cart_loader_top.sv
testbench/tb_cart_loader.sv

//--- Makefile
TOP  = tb_cart_loader
SRCS = $(wildcard logic/*.sv) $(wildcard testbench/*.sv testbench/*.svh)

all: run

obj_dir/V$(TOP): vlog.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || { echo "Simulation ended early"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean
